// File: verilog/ao_periph_config.svh
/* Always-on peripheral subsystem configuration
   Bus widths, fast interrupt count and block address map */

`ifndef AO_PERIPH_CONFIG_SVH
`define AO_PERIPH_CONFIG_SVH

`define AO_ADDR_W 32
`define AO_DATA_W 32
`define AO_REG_ADDR_W 8

`define AO_NUM_FAST_INTR 15

// Address bits 11 to 8 pick the block
`define AO_BLK_LSB 8
`define AO_BLK_W 4

`define AO_SOC_CTRL_BASE 32'h0000_0000
`define AO_FAST_INTR_BASE 32'h0000_0100
`define AO_TIMER_BASE 32'h0000_0200

`endif

// File: verilog/obi_pkg.sv
/* OBI bus types
   Request and response structs of the subsystem slave port */

`include "ao_periph_config.svh"

package obi_pkg;

  typedef logic [`AO_ADDR_W-1:0] obi_addr_t;
  typedef logic [`AO_DATA_W-1:0] obi_data_t;
  typedef logic [`AO_DATA_W/8-1:0] obi_be_t;

  typedef struct packed {
    logic      req;
    logic      we;
    obi_be_t   be;
    obi_addr_t addr;
    obi_data_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic      gnt;
    logic      rvalid;
    obi_data_t rdata;
    logic      err;
  } obi_resp_t;

endpackage

// File: verilog/reg_pkg.sv
/* Register bus types
   Request/response structs, decode and bridge enums, strobe merge helper */

`include "ao_periph_config.svh"

package reg_pkg;

  typedef logic [`AO_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`AO_DATA_W-1:0] reg_data_t;
  typedef logic [`AO_DATA_W/8-1:0] reg_strb_t;
  typedef logic [`AO_BLK_W-1:0] reg_blk_t;
  typedef logic [`AO_NUM_FAST_INTR-1:0] fast_intr_t;

  typedef struct packed {
    logic      valid;
    logic      write;
    reg_addr_t addr;
    reg_data_t wdata;
    reg_strb_t wstrb;
  } reg_req_t;

  // No ready since every access completes in its cycle
  typedef struct packed {
    reg_data_t rdata;
    logic      error;
  } reg_rsp_t;

  typedef enum logic [1:0] {
    SOC_CTRL,
    FAST_INTR,
    TIMER,
    NONE
  } periph_idx_e;

  typedef enum logic {
    IDLE,
    RESP
  } bridge_state_e;

  // Byte-wise update of a register word
  function automatic reg_data_t merge_wstrb(reg_data_t cur, reg_data_t wdata, reg_strb_t wstrb);
    reg_data_t res;
    res = cur;
    for (int i = 0; i < $bits(reg_strb_t); i++) begin
      if (wstrb[i]) begin
        res[8*i+:8] = wdata[8*i+:8];
      end
    end
    return res;
  endfunction

endpackage

// File: verilog/obi_to_reg.sv
/* OBI to register bus bridge
   Grants at once, forwards a one-cycle access, returns data with rvalid */

`include "ao_periph_config.svh"

module obi_to_reg (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  obi_pkg::obi_req_t  obi_req_i,
  output obi_pkg::obi_resp_t obi_resp_o,
  output reg_pkg::reg_req_t  reg_req_o,
  input  reg_pkg::reg_rsp_t  reg_rsp_i
);

  import reg_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;
  reg_data_t     rdata_q;
  logic          err_q;

  always_comb begin
    reg_req_o.valid = obi_req_i.req;
    reg_req_o.write = obi_req_i.we;
    reg_req_o.addr  = obi_req_i.addr[`AO_REG_ADDR_W-1:0];
    reg_req_o.wdata = obi_req_i.wdata;
    reg_req_o.wstrb = obi_req_i.be;
  end

  // A grant in RESP keeps the bridge in RESP for the overlapped transfer
  assign state_d = obi_req_i.req ? RESP : IDLE;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rdata_q <= reg_rsp_i.rdata;
      err_q   <= reg_rsp_i.error;
    end
  end

  always_comb begin
    obi_resp_o.gnt    = obi_req_i.req;
    obi_resp_o.rvalid = (state_q == RESP);
    obi_resp_o.rdata  = rdata_q;
    obi_resp_o.err    = err_q;
  end

endmodule

// File: verilog/reg_xbar.sv
/* Register bus crossbar
   Decodes the block field and steers the access to one peripheral */

`include "ao_periph_config.svh"

module reg_xbar (
  input  reg_pkg::reg_req_t in_req_i,
  output reg_pkg::reg_rsp_t in_rsp_o,
  input  reg_pkg::reg_blk_t addr_blk_i,
  output reg_pkg::reg_req_t soc_req_o,
  output reg_pkg::reg_req_t fast_req_o,
  output reg_pkg::reg_req_t tmr_req_o,
  input  reg_pkg::reg_rsp_t soc_rsp_i,
  input  reg_pkg::reg_rsp_t fast_rsp_i,
  input  reg_pkg::reg_rsp_t tmr_rsp_i
);

  import reg_pkg::*;

  localparam reg_blk_t SOC_BLK = reg_blk_t'(`AO_SOC_CTRL_BASE >> `AO_BLK_LSB);
  localparam reg_blk_t FAST_BLK = reg_blk_t'(`AO_FAST_INTR_BASE >> `AO_BLK_LSB);
  localparam reg_blk_t TMR_BLK = reg_blk_t'(`AO_TIMER_BASE >> `AO_BLK_LSB);

  periph_idx_e sel;

  always_comb begin
    case (addr_blk_i)
      SOC_BLK:  sel = SOC_CTRL;
      FAST_BLK: sel = FAST_INTR;
      TMR_BLK:  sel = TIMER;
      default:  sel = NONE;
    endcase
  end

  // Only the selected port sees valid
  always_comb begin
    soc_req_o        = in_req_i;
    fast_req_o       = in_req_i;
    tmr_req_o        = in_req_i;
    soc_req_o.valid  = in_req_i.valid && (sel == SOC_CTRL);
    fast_req_o.valid = in_req_i.valid && (sel == FAST_INTR);
    tmr_req_o.valid  = in_req_i.valid && (sel == TIMER);
  end

  always_comb begin
    case (sel)
      SOC_CTRL:  in_rsp_o = soc_rsp_i;
      FAST_INTR: in_rsp_o = fast_rsp_i;
      TIMER:     in_rsp_o = tmr_rsp_i;
      default: begin
        in_rsp_o.rdata = '0;
        in_rsp_o.error = 1'b1;
      end
    endcase
  end

endmodule

// File: verilog/soc_ctrl.sv
/* SoC control block
   Boot-select readback, exit value and sticky exit flag */

module soc_ctrl (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  reg_pkg::reg_req_t  reg_req_i,
  output reg_pkg::reg_rsp_t  reg_rsp_o,
  input  logic               boot_select_i,
  output logic               exit_valid_o,
  output obi_pkg::obi_data_t exit_value_o
);

  import reg_pkg::*;

  localparam reg_addr_t EXIT_VALID_OFS = 8'h00;
  localparam reg_addr_t EXIT_VALUE_OFS = 8'h04;
  localparam reg_addr_t BOOT_SELECT_OFS = 8'h08;

  logic      wr_en;
  logic      exit_valid_q;
  reg_data_t exit_value_q;

  assign wr_en = reg_req_i.valid & reg_req_i.write;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      case (reg_req_i.addr)
        // Once set, stays set until reset
        EXIT_VALID_OFS: begin
          if (reg_req_i.wstrb[0] && reg_req_i.wdata[0]) begin
            exit_valid_q <= 1'b1;
          end
        end
        EXIT_VALUE_OFS: begin
          exit_value_q <= merge_wstrb(exit_value_q, reg_req_i.wdata, reg_req_i.wstrb);
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.addr)
      EXIT_VALID_OFS:  reg_rsp_o.rdata = reg_data_t'(exit_valid_q);
      EXIT_VALUE_OFS:  reg_rsp_o.rdata = exit_value_q;
      BOOT_SELECT_OFS: reg_rsp_o.rdata = reg_data_t'(boot_select_i);
      default:         reg_rsp_o.error = 1'b1;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

// File: verilog/fast_intr_ctrl.sv
/* Fast interrupt controller
   Latches fast interrupt lines, masks them and clears by write-one */

module fast_intr_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  reg_pkg::reg_req_t   reg_req_i,
  output reg_pkg::reg_rsp_t   reg_rsp_o,
  input  reg_pkg::fast_intr_t fast_intr_i,
  output reg_pkg::fast_intr_t fast_intr_o
);

  import reg_pkg::*;

  localparam reg_addr_t PENDING_OFS = 8'h00;
  localparam reg_addr_t CLEAR_OFS = 8'h04;
  localparam reg_addr_t ENABLE_OFS = 8'h08;

  logic       wr_en;
  fast_intr_t clear_mask;
  fast_intr_t pending_q;
  fast_intr_t enable_q;
  fast_intr_t intr_q;

  assign wr_en = reg_req_i.valid & reg_req_i.write;
  assign clear_mask = (wr_en && reg_req_i.addr == CLEAR_OFS) ?
                      fast_intr_t'(reg_req_i.wdata) : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      intr_q    <= '0;
    end else begin
      // New set beats a clear in the same cycle
      pending_q <= (pending_q & ~clear_mask) | fast_intr_i;
      intr_q    <= pending_q & enable_q;
      if (wr_en && reg_req_i.addr == ENABLE_OFS) begin
        enable_q <= fast_intr_t'(merge_wstrb(reg_data_t'(enable_q), reg_req_i.wdata,
                                             reg_req_i.wstrb));
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.addr)
      PENDING_OFS: reg_rsp_o.rdata = reg_data_t'(pending_q);
      CLEAR_OFS:   reg_rsp_o.rdata = '0;
      ENABLE_OFS:  reg_rsp_o.rdata = reg_data_t'(enable_q);
      default:     reg_rsp_o.error = 1'b1;
    endcase
  end

  assign fast_intr_o = intr_q;

endmodule

// File: verilog/ao_timer.sv
/* Always-on timer
   Free-running counter with two compare interrupts */

module ao_timer (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  reg_pkg::reg_req_t reg_req_i,
  output reg_pkg::reg_rsp_t reg_rsp_o,
  output logic              timer_0_intr_o,
  output logic              timer_1_intr_o
);

  import reg_pkg::*;

  localparam reg_addr_t MTIME_OFS = 8'h00;
  localparam reg_addr_t CTRL_OFS = 8'h04;
  localparam reg_addr_t CMP0_OFS = 8'h08;
  localparam reg_addr_t CMP1_OFS = 8'h0C;

  logic      wr_en;
  logic      enable_q;
  reg_data_t mtime_q;
  reg_data_t mtime_d;
  reg_data_t cmp0_q;
  reg_data_t cmp1_q;
  logic      intr0_q;
  logic      intr1_q;

  assign wr_en = reg_req_i.valid & reg_req_i.write;

  // Software write takes priority over counting
  always_comb begin
    mtime_d = mtime_q;
    if (wr_en && reg_req_i.addr == MTIME_OFS) begin
      mtime_d = merge_wstrb(mtime_q, reg_req_i.wdata, reg_req_i.wstrb);
    end else if (enable_q) begin
      mtime_d = mtime_q + reg_data_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q  <= '0;
      enable_q <= 1'b0;
      cmp0_q   <= '1;
      cmp1_q   <= '1;
      intr0_q  <= 1'b0;
      intr1_q  <= 1'b0;
    end else begin
      mtime_q <= mtime_d;
      intr0_q <= (mtime_q >= cmp0_q);
      intr1_q <= (mtime_q >= cmp1_q);
      if (wr_en) begin
        case (reg_req_i.addr)
          CTRL_OFS: begin
            if (reg_req_i.wstrb[0]) begin
              enable_q <= reg_req_i.wdata[0];
            end
          end
          CMP0_OFS: cmp0_q <= merge_wstrb(cmp0_q, reg_req_i.wdata, reg_req_i.wstrb);
          CMP1_OFS: cmp1_q <= merge_wstrb(cmp1_q, reg_req_i.wdata, reg_req_i.wstrb);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.addr)
      MTIME_OFS: reg_rsp_o.rdata = mtime_q;
      CTRL_OFS:  reg_rsp_o.rdata = reg_data_t'(enable_q);
      CMP0_OFS:  reg_rsp_o.rdata = cmp0_q;
      CMP1_OFS:  reg_rsp_o.rdata = cmp1_q;
      default:   reg_rsp_o.error = 1'b1;
    endcase
  end

  assign timer_0_intr_o = intr0_q;
  assign timer_1_intr_o = intr1_q;

endmodule

// File: verilog/ao_peripheral_subsystem.sv
/* Always-on peripheral subsystem top
   OBI bridge, register crossbar, SoC control, fast interrupts and timer */

`include "ao_periph_config.svh"

module ao_peripheral_subsystem (
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  obi_pkg::obi_req_t   slave_req_i,
  output obi_pkg::obi_resp_t  slave_resp_o,

  // SoC control
  input  logic                boot_select_i,
  output logic                exit_valid_o,
  output obi_pkg::obi_data_t  exit_value_o,

  // Fast interrupts
  input  reg_pkg::fast_intr_t fast_intr_i,
  output reg_pkg::fast_intr_t fast_intr_o,

  // Timer
  output logic                rv_timer_0_intr_o,
  output logic                rv_timer_1_intr_o
);

  import reg_pkg::*;

  reg_req_t periph_req;
  reg_rsp_t periph_rsp;

  reg_req_t soc_req;
  reg_rsp_t soc_rsp;
  reg_req_t fast_req;
  reg_rsp_t fast_rsp;
  reg_req_t tmr_req;
  reg_rsp_t tmr_rsp;

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .rst_n_i,
    .obi_req_i (slave_req_i),
    .obi_resp_o(slave_resp_o),
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  // Bridge forwards in the same cycle, so the block field comes straight off the OBI address
  reg_xbar reg_xbar_i (
    .in_req_i  (periph_req),
    .in_rsp_o  (periph_rsp),
    .addr_blk_i(slave_req_i.addr[`AO_BLK_LSB+:`AO_BLK_W]),
    .soc_req_o (soc_req),
    .fast_req_o(fast_req),
    .tmr_req_o (tmr_req),
    .soc_rsp_i (soc_rsp),
    .fast_rsp_i(fast_rsp),
    .tmr_rsp_i (tmr_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(soc_req),
    .reg_rsp_o(soc_rsp),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(fast_req),
    .reg_rsp_o(fast_rsp),
    .fast_intr_i,
    .fast_intr_o
  );

  ao_timer ao_timer_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i     (tmr_req),
    .reg_rsp_o     (tmr_rsp),
    .timer_0_intr_o(rv_timer_0_intr_o),
    .timer_1_intr_o(rv_timer_1_intr_o)
  );

endmodule

// File: verif/ao_peripheral_subsystem_sva.sv
/* OBI handshake and reset assertions
   Bound to the subsystem top level */

module ao_peripheral_subsystem_sva (
  input logic               clk_i,
  input logic               rst_n_i,
  input obi_pkg::obi_req_t  slave_req_i,
  input obi_pkg::obi_resp_t slave_resp_i,
  input logic               exit_valid_i
);

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slave_resp_i.gnt |=> slave_resp_i.rvalid)
    else $error("rvalid missing one cycle after gnt");

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slave_resp_i.gnt |-> slave_req_i.req)
    else $error("gnt without req");

  // Exit flag is sticky
  exit_valid_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exit_valid_i |=> exit_valid_i)
    else $error("exit_valid_o fell while out of reset");

  rvalid_low_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !slave_resp_i.rvalid)
    else $error("rvalid high right after reset release");

endmodule

bind ao_peripheral_subsystem ao_peripheral_subsystem_sva i_ao_peripheral_subsystem_sva (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .slave_req_i (slave_req_i),
  .slave_resp_i(slave_resp_o),
  .exit_valid_i(exit_valid_o)
);

// File: verif/tb_ao_peripheral_subsystem.sv
/* Directed testbench for the always-on peripheral subsystem
   Drives the OBI slave port and checks registers, interrupts and timing */

`include "ao_periph_config.svh"

module tb_ao_peripheral_subsystem;

  import obi_pkg::*;
  import reg_pkg::*;

  // Limit well above the roughly 300 cycles of tests
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int GNT_WAIT_CYCLES = 16;

  localparam obi_addr_t EXIT_VALID_ADDR = `AO_SOC_CTRL_BASE + 32'h00;
  localparam obi_addr_t EXIT_VALUE_ADDR = `AO_SOC_CTRL_BASE + 32'h04;
  localparam obi_addr_t BOOT_SEL_ADDR = `AO_SOC_CTRL_BASE + 32'h08;
  localparam obi_addr_t SOC_HOLE_ADDR = `AO_SOC_CTRL_BASE + 32'h40;
  localparam obi_addr_t PENDING_ADDR = `AO_FAST_INTR_BASE + 32'h00;
  localparam obi_addr_t CLEAR_ADDR = `AO_FAST_INTR_BASE + 32'h04;
  localparam obi_addr_t ENABLE_ADDR = `AO_FAST_INTR_BASE + 32'h08;
  localparam obi_addr_t MTIME_ADDR = `AO_TIMER_BASE + 32'h00;
  localparam obi_addr_t CTRL_ADDR = `AO_TIMER_BASE + 32'h04;
  localparam obi_addr_t CMP0_ADDR = `AO_TIMER_BASE + 32'h08;
  localparam obi_addr_t CMP1_ADDR = `AO_TIMER_BASE + 32'h0C;
  localparam obi_addr_t BLK5_ADDR = 32'h0000_0500;

  logic       clk;
  logic       rst_n;
  obi_req_t   slave_req;
  obi_resp_t  slave_resp;
  logic       boot_select;
  logic       exit_valid;
  obi_data_t  exit_value;
  fast_intr_t fast_intr_in;
  fast_intr_t fast_intr_out;
  logic       timer_0_intr;
  logic       timer_1_intr;

  int checks;
  int errors;
  int cycles;

  ao_peripheral_subsystem i_ao_peripheral_subsystem (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .slave_req_i      (slave_req),
    .slave_resp_o     (slave_resp),
    .boot_select_i    (boot_select),
    .exit_valid_o     (exit_valid),
    .exit_value_o     (exit_value),
    .fast_intr_i      (fast_intr_in),
    .fast_intr_o      (fast_intr_out),
    .rv_timer_0_intr_o(timer_0_intr),
    .rv_timer_1_intr_o(timer_1_intr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_start);
    if (errors == errs_start) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: %0d mismatches", name, errors - errs_start);
    end
  endtask

  task automatic drive_req(input logic we, input obi_be_t be, input obi_addr_t addr,
                           input obi_data_t wdata);
    slave_req.req   = 1'b1;
    slave_req.we    = we;
    slave_req.be    = be;
    slave_req.addr  = addr;
    slave_req.wdata = wdata;
  endtask

  // Entered 2 units after an edge and left 2 units after the response edge
  task automatic obi_xfer(input logic we, input obi_be_t be, input obi_addr_t addr,
                          input obi_data_t wdata, output obi_data_t rdata,
                          output logic err);
    int waited;
    waited = 0;
    drive_req(we, be, addr, wdata);
    while (!slave_resp.gnt && waited < GNT_WAIT_CYCLES) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!slave_resp.gnt) begin
      errors++;
      $display("no grant for address 0x%08h after %0d cycles", addr, waited);
      slave_req.req = 1'b0;
      rdata = '0;
      err = 1'b1;
      return;
    end
    @(posedge clk);
    #2;
    slave_req.req = 1'b0;
    check_value("slave_resp_o.rvalid", 32'(slave_resp.rvalid), 32'h1);
    rdata = slave_resp.rdata;
    err = slave_resp.err;
  endtask

  task automatic obi_write(input obi_addr_t addr, input obi_data_t wdata, input obi_be_t be,
                           input logic exp_err);
    obi_data_t rdata;
    logic      err;
    obi_xfer(1'b1, be, addr, wdata, rdata, err);
    check_value("slave_resp_o.err", 32'(err), 32'(exp_err));
  endtask

  task automatic obi_read(input obi_addr_t addr, input logic exp_err, output obi_data_t rdata);
    logic err;
    obi_xfer(1'b0, 4'hF, addr, '0, rdata, err);
    check_value("slave_resp_o.err", 32'(err), 32'(exp_err));
  endtask

  task automatic test_reset_state();
    int        errs_start;
    obi_data_t rdata;
    errs_start = errors;
    check_value("slave_resp_o.rvalid", 32'(slave_resp.rvalid), 32'h0);
    check_value("exit_valid_o", 32'(exit_valid), 32'h0);
    check_value("exit_value_o", exit_value, 32'h0);
    check_value("fast_intr_o", 32'(fast_intr_out), 32'h0);
    check_value("rv_timer_0_intr_o", 32'(timer_0_intr), 32'h0);
    check_value("rv_timer_1_intr_o", 32'(timer_1_intr), 32'h0);
    obi_read(BOOT_SEL_ADDR, 1'b0, rdata);
    check_value("BOOT_SELECT", rdata, 32'h1);
    // Readback has to follow the pin both ways
    boot_select = 1'b0;
    obi_read(BOOT_SEL_ADDR, 1'b0, rdata);
    check_value("BOOT_SELECT", rdata, 32'h0);
    report_test("reset_state", errs_start);
  endtask

  task automatic test_soc_ctrl();
    int        errs_start;
    obi_data_t model;
    obi_data_t data;
    obi_data_t mask;
    obi_be_t   be;
    obi_data_t rdata;
    errs_start = errors;
    model = '0;
    for (int i = 0; i < 8; i++) begin
      data = $urandom;
      be = (i < 2) ? 4'hF : obi_be_t'($urandom);
      mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
      model = (model & ~mask) | (data & mask);
      obi_write(EXIT_VALUE_ADDR, data, be, 1'b0);
      obi_read(EXIT_VALUE_ADDR, 1'b0, rdata);
      check_value("EXIT_VALUE", rdata, model);
      check_value("exit_value_o", exit_value, model);
    end
    obi_write(EXIT_VALID_ADDR, 32'h1, 4'hF, 1'b0);
    check_value("exit_valid_o", 32'(exit_valid), 32'h1);
    // Flag is sticky
    obi_write(EXIT_VALID_ADDR, 32'h0, 4'hF, 1'b0);
    check_value("exit_valid_o", 32'(exit_valid), 32'h1);
    obi_read(EXIT_VALID_ADDR, 1'b0, rdata);
    check_value("EXIT_VALID", rdata, 32'h1);
    report_test("soc_ctrl", errs_start);
  endtask

  task automatic test_fast_intr();
    int         errs_start;
    fast_intr_t mask;
    fast_intr_t pulse;
    obi_data_t  rdata;
    errs_start = errors;
    mask = fast_intr_t'($urandom) | fast_intr_t'(1);
    pulse = fast_intr_t'($urandom) | fast_intr_t'(1);
    obi_write(ENABLE_ADDR, 32'(mask), 4'hF, 1'b0);
    obi_read(ENABLE_ADDR, 1'b0, rdata);
    check_value("ENABLE", rdata, 32'(mask));
    fast_intr_in = pulse;
    @(posedge clk);
    #2;
    fast_intr_in = '0;
    @(posedge clk);
    #2;
    check_value("fast_intr_o", 32'(fast_intr_out), 32'(pulse & mask));
    obi_read(PENDING_ADDR, 1'b0, rdata);
    check_value("PENDING", rdata, 32'(pulse));
    obi_write(CLEAR_ADDR, 32'(pulse), 4'hF, 1'b0);
    obi_read(PENDING_ADDR, 1'b0, rdata);
    check_value("PENDING", rdata, 32'h0);
    check_value("fast_intr_o", 32'(fast_intr_out), 32'h0);
    report_test("fast_intr", errs_start);
  endtask

  task automatic test_timer();
    int        errs_start;
    obi_data_t rdata;
    errs_start = errors;
    obi_write(MTIME_ADDR, 32'h0, 4'hF, 1'b0);
    obi_write(CMP0_ADDR, 32'd40, 4'hF, 1'b0);
    obi_write(CMP1_ADDR, 32'hFFFF_FFFF, 4'hF, 1'b0);
    obi_write(CTRL_ADDR, 32'h1, 4'hF, 1'b0);
    check_value("rv_timer_0_intr_o", 32'(timer_0_intr), 32'h0);
    repeat (80) @(posedge clk);
    #2;
    check_value("rv_timer_0_intr_o", 32'(timer_0_intr), 32'h1);
    check_value("rv_timer_1_intr_o", 32'(timer_1_intr), 32'h0);
    obi_read(MTIME_ADDR, 1'b0, rdata);
    check_value("MTIME >= 80", 32'(rdata >= 32'd80), 32'h1);
    report_test("timer", errs_start);
  endtask

  task automatic test_errors_b2b();
    int        errs_start;
    obi_data_t saved;
    obi_data_t data;
    obi_data_t rdata;
    errs_start = errors;
    obi_read(BLK5_ADDR, 1'b1, rdata);
    check_value("rdata of block 5", rdata, 32'h0);
    obi_read(EXIT_VALUE_ADDR, 1'b0, saved);
    obi_write(SOC_HOLE_ADDR, $urandom, 4'hF, 1'b1);
    obi_read(SOC_HOLE_ADDR, 1'b1, rdata);
    check_value("rdata of offset 0x40", rdata, 32'h0);
    obi_read(EXIT_VALUE_ADDR, 1'b0, rdata);
    check_value("EXIT_VALUE", rdata, saved);

    // Write then read held back-to-back with overlapping responses
    data = $urandom;
    drive_req(1'b1, 4'hF, EXIT_VALUE_ADDR, data);
    check_value("slave_resp_o.gnt", 32'(slave_resp.gnt), 32'h1);
    @(posedge clk);
    #2;
    drive_req(1'b0, 4'hF, EXIT_VALUE_ADDR, '0);
    check_value("slave_resp_o.rvalid", 32'(slave_resp.rvalid), 32'h1);
    check_value("slave_resp_o.err", 32'(slave_resp.err), 32'h0);
    check_value("slave_resp_o.gnt", 32'(slave_resp.gnt), 32'h1);
    @(posedge clk);
    #2;
    slave_req.req = 1'b0;
    check_value("slave_resp_o.rvalid", 32'(slave_resp.rvalid), 32'h1);
    check_value("slave_resp_o.rdata", slave_resp.rdata, data);
    check_value("slave_resp_o.err", 32'(slave_resp.err), 32'h0);
    @(posedge clk);
    #2;
    check_value("slave_resp_o.rvalid", 32'(slave_resp.rvalid), 32'h0);
    report_test("errors_b2b", errs_start);
  endtask

  initial begin
    void'($urandom(26));
    rst_n = 1'b0;
    slave_req = '0;
    boot_select = 1'b1;
    fast_intr_in = '0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_reset_state();
    test_soc_ctrl();
    test_fast_intr();
    test_timer();
    test_errors_b2b();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: ao_peripheral_subsystem.f
+incdir+verilog
verilog/obi_pkg.sv
verilog/reg_pkg.sv
verilog/obi_to_reg.sv
verilog/reg_xbar.sv
verilog/soc_ctrl.sv
verilog/fast_intr_ctrl.sv
verilog/ao_timer.sv
verilog/ao_peripheral_subsystem.sv
verif/ao_peripheral_subsystem_sva.sv
verif/tb_ao_peripheral_subsystem.sv

// File: Makefile
TOP = tb_ao_peripheral_subsystem
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f ao_peripheral_subsystem.f \
		--top-module $(TOP) --Mdir obj_dir

run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

lint:
	verilator --lint-only --timing --assert -f ao_peripheral_subsystem.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
